// File: logic/accel_data_pkg.sv
package accel_data_pkg;

    // Array geometry
    localparam int ROWS = 8;
    localparam int COLS = 8;

    // Operand and result widths
    localparam int ACT_W  = 4;
    localparam int WGT_W  = 4;
    localparam int PSUM_W = 16;

    localparam int ROW_IDX_W = $clog2(ROWS);

    // Activations are unsigned, weights and sums two's complement
    typedef logic [ACT_W-1:0] act_t;
    typedef logic signed [WGT_W-1:0] wgt_t;
    typedef logic signed [PSUM_W-1:0] psum_t;

    // Row of activations, element r at bits [r*ACT_W +: ACT_W]
    typedef logic [ROWS*ACT_W-1:0] act_vec_t;

    // One weight per column
    typedef logic [COLS*WGT_W-1:0] wgt_vec_t;

    // One partial sum per column
    typedef logic [COLS*PSUM_W-1:0] psum_vec_t;

    typedef logic [ROW_IDX_W-1:0] row_idx_t;

endpackage

// File: logic/accel_ctrl_pkg.sv
package accel_ctrl_pkg;

    // Mode levels for the special function stage
    typedef struct packed {
        logic acc;
        logic max_pool_en;
        logic bypass;
    } sfu_ctrl_t;

    // Write of one weight row, column c takes data[c*WGT_W +: WGT_W]
    typedef struct packed {
        logic                     load;
        accel_data_pkg::row_idx_t row;
        accel_data_pkg::wgt_vec_t data;
    } wgt_write_t;

endpackage

// File: logic/mac_column.sv
`timescale 1ns/10ps

module mac_column #(
    parameter int COL_IDX = 0
) (
    input  logic                       clk,
    input  logic                       reset,
    input  accel_ctrl_pkg::wgt_write_t wgt_write_i,
    input  accel_data_pkg::act_vec_t   act_i,
    output accel_data_pkg::psum_t      psum_o
);

    import accel_data_pkg::*;

    wgt_t  wgt_q [ROWS];
    psum_t dot_w;

    // Weight storage, one entry per array row
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int r = 0; r < ROWS; r++) begin
                wgt_q[r] <= '0;
            end
        end else if (wgt_write_i.load) begin
            wgt_q[wgt_write_i.row] <= wgt_write_i.data[COL_IDX*WGT_W +: WGT_W];
        end
    end

    // Zero-extend activations, sign-extend weights
    always_comb begin : dot_product
        psum_t act_ext;
        psum_t wgt_ext;
        act_ext = '0;
        wgt_ext = '0;
        dot_w   = '0;
        for (int r = 0; r < ROWS; r++) begin
            act_ext = psum_t'(act_t'(act_i[r*ACT_W +: ACT_W]));
            wgt_ext = psum_t'(wgt_q[r]);
            dot_w   = dot_w + act_ext * wgt_ext;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            psum_o <= '0;
        end else begin
            psum_o <= dot_w;
        end
    end

endmodule

// File: logic/mac_array.sv
`timescale 1ns/10ps

module mac_array (
    input  logic                       clk,
    input  logic                       reset,
    input  accel_ctrl_pkg::wgt_write_t wgt_write_i,
    input  accel_data_pkg::act_vec_t   act_i,
    input  accel_ctrl_pkg::sfu_ctrl_t  ctrl_i,
    output accel_data_pkg::psum_vec_t  psum_o,
    output accel_ctrl_pkg::sfu_ctrl_t  ctrl_o
);

    import accel_data_pkg::*;
    import accel_ctrl_pkg::*;

    psum_t col_psum_w [COLS];

    // Each column registers its own sum, so the array adds one cycle
    for (genvar c = 0; c < COLS; c++) begin : g_col
        mac_column #(
            .COL_IDX (c)
        ) u_col (
            .clk         (clk),
            .reset       (reset),
            .wgt_write_i (wgt_write_i),
            .act_i       (act_i),
            .psum_o      (col_psum_w[c])
        );

        assign psum_o[c*PSUM_W +: PSUM_W] = col_psum_w[c];
    end

    // Control follows its data through the same register stage
    sfu_ctrl_t ctrl_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q <= ctrl_i;
        end
    end

    assign ctrl_o = ctrl_q;

endmodule

// File: logic/sfu_max_pool.sv
`timescale 1ns/10ps

module sfu_max_pool (
    input  logic                      clk,
    input  logic                      reset,
    input  accel_ctrl_pkg::sfu_ctrl_t ctrl_i,
    input  accel_data_pkg::psum_vec_t psum_i,
    output accel_data_pkg::psum_vec_t psum_o
);

    import accel_data_pkg::*;

    logic acc_q;
    logic max_pool_en_q;

    psum_vec_t acc_sum_q;
    psum_vec_t pool_q;
    psum_vec_t acc_next_w;
    psum_vec_t pool_next_w;

    // Window edges from the registered levels
    logic acc_start_w;
    logic acc_out_w;
    logic pool_start_w;
    logic pool_out_w;

    assign acc_start_w  = ctrl_i.acc & ~acc_q;
    assign acc_out_w    = acc_q & ~ctrl_i.acc;
    assign pool_start_w = ctrl_i.max_pool_en & ~max_pool_en_q;
    assign pool_out_w   = max_pool_en_q & ~ctrl_i.max_pool_en;

    for (genvar c = 0; c < COLS; c++) begin : g_col
        psum_t in_w;
        psum_t acc_w;
        psum_t pool_w;
        psum_t sum_w;
        psum_t relu_in_w;
        psum_t relu_acc_w;
        psum_t max_w;

        assign in_w   = psum_i[c*PSUM_W +: PSUM_W];
        assign acc_w  = acc_sum_q[c*PSUM_W +: PSUM_W];
        assign pool_w = pool_q[c*PSUM_W +: PSUM_W];

        assign sum_w      = acc_w + in_w;
        assign relu_in_w  = in_w[PSUM_W-1] ? '0 : in_w;
        assign relu_acc_w = acc_w[PSUM_W-1] ? '0 : acc_w;

        // Both sides already through ReLU
        assign max_w = ($unsigned(pool_w) > $unsigned(relu_in_w)) ? pool_w : relu_in_w;

        assign acc_next_w[c*PSUM_W +: PSUM_W]  = acc_start_w ? in_w : sum_w;
        assign pool_next_w[c*PSUM_W +: PSUM_W] = pool_start_w ? relu_in_w : max_w;

        // Bypass wins, then pooled result, then accumulated result
        assign psum_o[c*PSUM_W +: PSUM_W] = ctrl_i.bypass ? in_w :
                                            pool_out_w    ? pool_w :
                                            acc_out_w     ? relu_acc_w :
                                                            relu_in_w;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            acc_q         <= 1'b0;
            max_pool_en_q <= 1'b0;
            acc_sum_q     <= '0;
            pool_q        <= '0;
        end else begin
            acc_q         <= ctrl_i.acc;
            max_pool_en_q <= ctrl_i.max_pool_en;
            // Registers hold their value outside a window
            if (ctrl_i.acc) begin
                acc_sum_q <= acc_next_w;
            end
            if (ctrl_i.max_pool_en) begin
                pool_q <= pool_next_w;
            end
        end
    end

endmodule

// File: logic/psum_accel_top.sv
`timescale 1ns/10ps

module psum_accel_top (
    input  logic                       clk,
    input  logic                       reset,
    input  accel_ctrl_pkg::wgt_write_t wgt_write_i,
    input  accel_data_pkg::act_vec_t   act_i,
    input  accel_ctrl_pkg::sfu_ctrl_t  ctrl_i,
    output accel_data_pkg::psum_vec_t  psum_o
);

    import accel_data_pkg::*;
    import accel_ctrl_pkg::*;

    // Array output, control aligned to it
    psum_vec_t array_psum;
    sfu_ctrl_t ctrl_q;

    mac_array u_mac_array (
        .clk         (clk),
        .reset       (reset),
        .wgt_write_i (wgt_write_i),
        .act_i       (act_i),
        .ctrl_i      (ctrl_i),
        .psum_o      (array_psum),
        .ctrl_o      (ctrl_q)
    );

    // Combinational output stage
    sfu_max_pool u_sfu (
        .clk    (clk),
        .reset  (reset),
        .ctrl_i (ctrl_q),
        .psum_i (array_psum),
        .psum_o (psum_o)
    );

endmodule

// File: verification/psum_accel_asserts.sv
`timescale 1ns/10ps

module sfu_max_pool_asserts (
    input logic                      clk,
    input logic                      reset,
    input accel_ctrl_pkg::sfu_ctrl_t ctrl_i,
    input accel_data_pkg::psum_vec_t psum_i,
    input accel_data_pkg::psum_vec_t psum_o,
    input logic                      acc_q,
    input accel_data_pkg::psum_vec_t pool_q,
    input accel_data_pkg::psum_vec_t acc_sum_q
);

    import accel_data_pkg::*;

    int fail_count = 0;

    logic [COLS-1:0] pool_sign_w;

    for (genvar c = 0; c < COLS; c++) begin : g_sign
        assign pool_sign_w[c] = pool_q[c*PSUM_W + PSUM_W - 1];
    end

    bypass_passes_sum: assert property (@(posedge clk) disable iff (reset)
        ctrl_i.bypass |-> psum_o == psum_i)
    else begin
        $error("bypass set but output differs from input");
        fail_count++;
    end

    // Pooled values come from ReLU only
    pool_non_negative: assert property (@(posedge clk) disable iff (reset)
        pool_sign_w == '0)
    else begin
        $error("pooling register holds a negative value");
        fail_count++;
    end

    acc_level_registered: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> acc_q == $past(ctrl_i.acc))
    else begin
        $error("registered acc does not follow acc input");
        fail_count++;
    end

    reset_clears_state: assert property (@(posedge clk)
        reset && $past(reset) |-> acc_q == 1'b0 && pool_q == '0 && acc_sum_q == '0
                                  && psum_o == '0)
    else begin
        $error("state or output not zero during reset");
        fail_count++;
    end

endmodule

bind sfu_max_pool sfu_max_pool_asserts u_asserts (
    .clk       (clk),
    .reset     (reset),
    .ctrl_i    (ctrl_i),
    .psum_i    (psum_i),
    .psum_o    (psum_o),
    .acc_q     (acc_q),
    .pool_q    (pool_q),
    .acc_sum_q (acc_sum_q)
);

// File: verification/psum_accel_tb.sv
`timescale 1ns/10ps

module psum_accel_tb;

    import accel_data_pkg::*;
    import accel_ctrl_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;

    localparam sfu_ctrl_t MODE_IDLE   = '{acc: 1'b0, max_pool_en: 1'b0, bypass: 1'b0};
    localparam sfu_ctrl_t MODE_BYPASS = '{acc: 1'b0, max_pool_en: 1'b0, bypass: 1'b1};
    localparam sfu_ctrl_t MODE_ACC    = '{acc: 1'b1, max_pool_en: 1'b0, bypass: 1'b0};
    localparam sfu_ctrl_t MODE_POOL   = '{acc: 1'b0, max_pool_en: 1'b1, bypass: 1'b0};

    // One table row with stimulus, check flag and fixed result or model
    typedef struct packed {
        act_vec_t   act;
        sfu_ctrl_t  ctrl;
        logic       check;
        logic       use_model;
        psum_vec_t  exp;
        wgt_write_t wr;
    } stim_t;

    logic       clk;
    logic       reset;
    wgt_write_t wgt_write_i;
    act_vec_t   act_i;
    sfu_ctrl_t  ctrl_i;
    psum_vec_t  psum_o;

    stim_t stim_q[$];
    logic  table_ready = 1'b0;
    int    error_count;
    int    check_count;

    // Reference model state
    wgt_t  wgt_m [ROWS][COLS];
    logic  acc_q_m;
    logic  pool_q_m;
    psum_t acc_sum_m [COLS];
    psum_t pool_m [COLS];

    psum_accel_top dut (
        .clk         (clk),
        .reset       (reset),
        .wgt_write_i (wgt_write_i),
        .act_i       (act_i),
        .ctrl_i      (ctrl_i),
        .psum_o      (psum_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic psum_t col_dot(act_vec_t act, int col);
        int sum;
        sum = 0;
        for (int r = 0; r < ROWS; r++) begin
            sum += int'(act[r*ACT_W +: ACT_W]) * int'(wgt_m[r][col]);
        end
        return psum_t'(sum);
    endfunction

    function automatic psum_t relu(psum_t v);
        return (int'(v) < 0) ? psum_t'(0) : v;
    endfunction

    task automatic apply_write(input wgt_write_t w);
        if (w.load) begin
            for (int c = 0; c < COLS; c++) begin
                wgt_m[w.row][c] = wgt_t'(w.data[c*WGT_W +: WGT_W]);
            end
        end
    endtask

    // Output for one entry, then window registers and weights advance
    task automatic model_step(input stim_t s, output psum_vec_t exp_v);
        psum_t in_s;
        psum_t res;
        logic  acc_end;
        logic  pool_end;
        acc_end  = acc_q_m & ~s.ctrl.acc;
        pool_end = pool_q_m & ~s.ctrl.max_pool_en;
        exp_v    = '0;
        for (int c = 0; c < COLS; c++) begin
            in_s = col_dot(s.act, c);
            if (s.ctrl.bypass) begin
                res = in_s;
            end else if (pool_end) begin
                res = pool_m[c];
            end else if (acc_end) begin
                res = relu(acc_sum_m[c]);
            end else begin
                res = relu(in_s);
            end
            exp_v[c*PSUM_W +: PSUM_W] = res;
            if (s.ctrl.acc) begin
                acc_sum_m[c] = acc_q_m ? acc_sum_m[c] + in_s : in_s;
            end
            if (s.ctrl.max_pool_en) begin
                if (!pool_q_m || relu(in_s) > pool_m[c]) begin
                    pool_m[c] = relu(in_s);
                end
            end
        end
        acc_q_m  = s.ctrl.acc;
        pool_q_m = s.ctrl.max_pool_en;
        apply_write(s.wr);
    endtask

    task automatic check_psum(input string name, input psum_t exp, input psum_t got);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[FAIL] %s: expected 0x%04h, got 0x%04h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic check_psum_vec(input string name, input psum_vec_t exp, input psum_vec_t got);
        psum_t e;
        psum_t g;
        check_count++;
        for (int c = 0; c < COLS; c++) begin
            e = exp[c*PSUM_W +: PSUM_W];
            g = got[c*PSUM_W +: PSUM_W];
            if (g !== e) begin
                error_count++;
                $display("[FAIL] %s[%0d]: expected 0x%04h, got 0x%04h at %0t",
                         name, c, e, g, $time);
            end
        end
    endtask

    // Column 0 weights always negative and column 1 weights positive and nonzero
    function automatic wgt_vec_t random_weights();
        wgt_vec_t d;
        d = wgt_vec_t'($urandom);
        d[WGT_W-1]   = 1'b1;
        d[2*WGT_W-1] = 1'b0;
        d[WGT_W]     = 1'b1;
        return d;
    endfunction

    function automatic act_vec_t rand_act();
        return act_vec_t'($urandom);
    endfunction

    task automatic add_stim(
        input act_vec_t   act,
        input sfu_ctrl_t  ctrl,
        input logic       check,
        input logic       use_model,
        input psum_vec_t  exp,
        input wgt_write_t wr
    );
        stim_t s;
        s.act       = act;
        s.ctrl      = ctrl;
        s.check     = check;
        s.use_model = use_model;
        s.exp       = exp;
        s.wr        = wr;
        stim_q.push_back(s);
    endtask

    task automatic add_model(input act_vec_t act, input sfu_ctrl_t ctrl);
        add_stim(act, ctrl, 1'b1, 1'b1, '0, '0);
    endtask

    task automatic build_table();
        int         lens [3];
        act_vec_t   act_max;
        act_vec_t   act_ones;
        act_vec_t   act_a;
        act_vec_t   act_b;
        wgt_write_t wr;
        lens     = '{3, 5, 4};
        act_max  = '1;
        act_ones = {ROWS{4'h1}};

        // Raw signed sums including negatives
        for (int k = 0; k < 6; k++) begin
            add_model(rand_act(), MODE_BYPASS);
        end
        add_model(act_max, MODE_BYPASS);
        add_stim('0, MODE_BYPASS, 1'b1, 1'b0, '0, '0);
        add_stim('0, MODE_IDLE, 1'b1, 1'b0, '0, '0);

        // ReLU on single sums
        for (int k = 0; k < 6; k++) begin
            add_model(rand_act(), MODE_IDLE);
        end

        // Accumulate windows with the result in the cycle after acc falls
        foreach (lens[w]) begin
            for (int k = 0; k < lens[w]; k++) begin
                add_model(rand_act(), MODE_ACC);
            end
            add_model(rand_act(), MODE_IDLE);
        end

        // Second pooling window has smaller sums than the first maximum
        for (int k = 0; k < 4; k++) begin
            add_model((k == 2) ? act_max : rand_act(), MODE_POOL);
        end
        add_model(rand_act(), MODE_IDLE);
        for (int k = 0; k < 4; k++) begin
            add_model(act_ones, MODE_POOL);
        end
        add_model(rand_act(), MODE_IDLE);

        // Rewrite row 3 only
        act_a = rand_act();
        act_a[3*ACT_W +: ACT_W] = 4'hf;
        act_b = rand_act();
        act_b[3*ACT_W +: ACT_W] = 4'h0;
        wr.load = 1'b1;
        wr.row  = row_idx_t'(3);
        wr.data = random_weights();
        add_model(act_a, MODE_BYPASS);
        add_stim(act_b, MODE_BYPASS, 1'b1, 1'b1, '0, wr);
        add_model(act_b, MODE_BYPASS);
        add_model(act_a, MODE_BYPASS);

        // Mixed modes
        for (int k = 0; k < 12; k++) begin
            add_model(rand_act(), sfu_ctrl_t'(3'($urandom_range(7, 0))));
        end
    endtask

    task automatic drive_stim(input stim_t s);
        act_i       <= s.act;
        ctrl_i      <= s.ctrl;
        wgt_write_i <= s.wr;
    endtask

    task automatic check_entry(input stim_t s);
        psum_vec_t exp_v;
        model_step(s, exp_v);
        if (s.check) begin
            check_psum_vec("psum_o", s.use_model ? exp_v : s.exp, psum_o);
        end
    endtask

    initial begin : watchdog
        wait (table_ready);
        #((RESET_CYCLES + ROWS + stim_q.size() + 20) * CLK_PERIOD);
        $display("Timeout: the test sequence did not finish in the expected time");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : main
        wgt_write_t w;
        int         assert_fails;
        void'($urandom(32'h2b3f));
        error_count = 0;
        check_count = 0;
        clk         = 1'b0;
        reset       = 1'b1;
        wgt_write_i = '0;
        act_i       = '0;
        ctrl_i      = '0;
        acc_q_m     = 1'b0;
        pool_q_m    = 1'b0;
        for (int c = 0; c < COLS; c++) begin
            acc_sum_m[c] = '0;
            pool_m[c]    = '0;
            for (int r = 0; r < ROWS; r++) begin
                wgt_m[r][c] = '0;
            end
        end
        build_table();
        table_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        for (int c = 0; c < COLS; c++) begin
            check_psum($sformatf("psum_o[%0d]", c), '0, psum_o[c*PSUM_W +: PSUM_W]);
        end

        for (int r = 0; r < ROWS; r++) begin
            w.load = 1'b1;
            w.row  = row_idx_t'(r);
            w.data = random_weights();
            @(posedge clk);
            wgt_write_i <= w;
            apply_write(w);
        end

        // Output of entry i-1 is valid while entry i is applied
        for (int i = 0; i < stim_q.size(); i++) begin
            @(posedge clk);
            drive_stim(stim_q[i]);
            @(negedge clk);
            if (i > 0) begin
                check_entry(stim_q[i-1]);
            end
        end
        @(posedge clk);
        wgt_write_i <= '0;
        act_i       <= '0;
        ctrl_i      <= '0;
        @(negedge clk);
        check_entry(stim_q[stim_q.size()-1]);

        assert_fails = dut.u_sfu.u_asserts.fail_count;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: sim.f
logic/accel_data_pkg.sv
logic/accel_ctrl_pkg.sv
logic/mac_column.sv
logic/mac_array.sv
logic/sfu_max_pool.sv
logic/psum_accel_top.sv
verification/psum_accel_asserts.sv
verification/psum_accel_tb.sv

// File: Makefile
# Verilator simulation of the partial-sum accelerator

LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module psum_accel_tb -f sim.f -Mdir obj_dir
	./obj_dir/Vpsum_accel_tb | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
